/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = cpuTb
FILELIST = compile.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fails on a failing run"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* compile.f */
+incdir+hdl
hdl/archPkg.sv
hdl/controlPkg.sv
hdl/controller.sv
hdl/addressUnit.sv
hdl/dataCapture.sv
hdl/registerFile.sv
hdl/execute.sv
hdl/cpu32.sv
tests/cpu_sva.sv
tests/cpuTb.sv

/* hdl/addressUnit.sv */
`include "cpu_consts.svh"

module addressUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  controlPkg::controlBus ctrl,
    input  archPkg::instrWord     instructionReg,
    input  logic [31:0]           aluResult,
    input  logic [31:0]           registerFileB,
    output logic [31:0]           address,
    output logic [31:0]           dataOut,
    output logic [3:0]            bwe
);

    logic [31:0] pc;
    logic [31:0] branchOffset;
    logic [1:0]  lane;

    // word offset, relative to the already incremented pc
    assign branchOffset = {{14{instructionReg.iForm.imm16[15]}}, instructionReg.iForm.imm16, 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_VECTOR;
        end else if (ctrl.pcBranch) begin
            pc <= pc + branchOffset;
        end else if (ctrl.pcIncrement) begin
            pc <= pc + 32'(`BYTE_LANES);
        end
    end

    assign address = ctrl.useDataAddress ? aluResult : pc;
    assign lane    = address[1:0];

    always_comb begin
        bwe     = '0;
        dataOut = registerFileB;
        if (ctrl.byteStore) begin
            dataOut = '0;
            for (int i = 0; i < `BYTE_LANES; i++) begin
                if (lane == i[1:0]) begin
                    dataOut[i*8 +: 8] = registerFileB[7:0];
                    bwe[i]            = ctrl.write;
                end
            end
        end else if (ctrl.write) begin
            bwe = '1;  // full word
        end
    end

endmodule

/* hdl/archPkg.sv */
package archPkg;

    typedef enum logic [5:0] {
        OP_ADD  = 6'h00,
        OP_SUB  = 6'h01,
        OP_AND  = 6'h02,
        OP_OR   = 6'h03,
        OP_XOR  = 6'h04,
        OP_SHL  = 6'h05,
        OP_SHR  = 6'h06,
        OP_SAR  = 6'h07,
        OP_ADDI = 6'h08,
        OP_LUI  = 6'h09,
        OP_LW   = 6'h0a,
        OP_SW   = 6'h0b,
        OP_SB   = 6'h0c,
        OP_BR   = 6'h0d,
        OP_HALT = 6'h3f  // unlisted codes also halt
    } opcodes;

    // branch condition, held in the low bits of rd
    typedef enum logic [3:0] {
        AL = 4'h0,
        EQ = 4'h1,
        NE = 4'h2,
        CS = 4'h3,
        CC = 4'h4,
        MI = 4'h5,
        PL = 4'h6,
        VS = 4'h7,
        VC = 4'h8
    } conditions;

    typedef struct packed {
        opcodes      opcode;
        logic [4:0]  rd;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [10:0] spare;
    } rFormFields;

    typedef struct packed {
        opcodes             opcode;
        logic [4:0]         rd;
        logic [4:0]         ra;
        logic signed [15:0] imm16;
    } iFormFields;

    typedef union packed {
        rFormFields rForm;
        iFormFields iForm;
    } instrWord;

    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;
        logic overflow;
    } flagBits;

endpackage

/* hdl/controlPkg.sv */
package controlPkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR,
        ALU_SAR,
        ALU_PASSB
    } aluOps;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_UPPER  // imm16 << 16
    } wbSources;

    typedef struct packed {
        // bus request
        logic     read;
        logic     write;
        logic     useDataAddress;  // aluResult instead of pc
        logic     byteStore;
        // capture
        logic     loadInstr;
        logic     loadData;
        // operands and alu
        logic     loadOperands;
        logic     useImmediate;
        logic     readRdAsB;
        aluOps    aluOp;
        logic     setFlags;
        // write back and pc
        logic     regWrite;
        wbSources wbSource;
        logic     pcIncrement;
        logic     pcBranch;
    } controlBus;

endpackage

/* hdl/controller.sv */
module controller (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  waitRequest,
    input  logic                  readValid,
    input  archPkg::instrWord     instructionReg,
    input  archPkg::flagBits      flags,
    output controlPkg::controlBus ctrl,
    output logic                  halted
);

    import archPkg::*;
    import controlPkg::*;

    typedef enum logic [2:0] {
        FETCH,
        FETCHWAIT,
        DECODE,
        EXECUTE,
        MEMORY,
        MEMWAIT,
        WRITEBACK,
        HALT
    } states;

    states     state;
    opcodes    opcode;
    conditions condition;
    aluOps     aluOp;
    logic      busRead;  // request flops, held until accepted
    logic      busWrite;
    logic      isAlu;
    logic      isUpper;
    logic      isLoad;
    logic      isStore;
    logic      isBranch;
    logic      useImm;
    logic      branchTaken;

    assign opcode    = instructionReg.rForm.opcode;
    assign condition = conditions'(instructionReg.iForm.rd[3:0]);
    assign halted    = state == HALT;

    // opcode decode, independent of state so the alu result stays put during memory
    always_comb begin
        aluOp    = ALU_PASSB;
        isAlu    = 1'b0;
        isUpper  = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        useImm   = 1'b0;
        case (opcode)
            OP_ADD: begin
                aluOp = ALU_ADD;
                isAlu = 1'b1;
            end
            OP_SUB: begin
                aluOp = ALU_SUB;
                isAlu = 1'b1;
            end
            OP_AND: begin
                aluOp = ALU_AND;
                isAlu = 1'b1;
            end
            OP_OR: begin
                aluOp = ALU_OR;
                isAlu = 1'b1;
            end
            OP_XOR: begin
                aluOp = ALU_XOR;
                isAlu = 1'b1;
            end
            OP_SHL: begin
                aluOp = ALU_SHL;
                isAlu = 1'b1;
            end
            OP_SHR: begin
                aluOp = ALU_SHR;
                isAlu = 1'b1;
            end
            OP_SAR: begin
                aluOp = ALU_SAR;
                isAlu = 1'b1;
            end
            OP_ADDI: begin
                aluOp  = ALU_ADD;
                isAlu  = 1'b1;
                useImm = 1'b1;
            end
            OP_LUI:  isUpper = 1'b1;
            OP_LW: begin
                aluOp  = ALU_ADD;  // ra + imm
                isLoad = 1'b1;
                useImm = 1'b1;
            end
            OP_SW, OP_SB: begin
                aluOp   = ALU_ADD;
                isStore = 1'b1;
                useImm  = 1'b1;
            end
            OP_BR:   isBranch = 1'b1;
            default: ;  // halt
        endcase
    end

    always_comb begin
        case (condition)
            AL:      branchTaken = 1'b1;
            EQ:      branchTaken = flags.zero;
            NE:      branchTaken = !flags.zero;
            CS:      branchTaken = flags.carry;
            CC:      branchTaken = !flags.carry;
            MI:      branchTaken = flags.negative;
            PL:      branchTaken = !flags.negative;
            VS:      branchTaken = flags.overflow;
            VC:      branchTaken = !flags.overflow;
            default: branchTaken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= FETCH;
            busRead  <= 1'b0;
            busWrite <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    busRead <= 1'b1;
                    state   <= FETCHWAIT;
                end
                FETCHWAIT: begin
                    if (busRead) begin
                        if (!waitRequest) busRead <= 1'b0;
                    end else if (readValid) begin
                        state <= DECODE;
                    end
                end
                DECODE:  state <= EXECUTE;
                EXECUTE: begin
                    if (isLoad || isStore) state <= MEMORY;
                    else if (isBranch) state <= FETCH;
                    else if (isAlu || isUpper) state <= WRITEBACK;
                    else state <= HALT;
                end
                MEMORY: begin
                    busRead  <= isLoad;
                    busWrite <= isStore;
                    state    <= MEMWAIT;
                end
                MEMWAIT: begin
                    if (busRead || busWrite) begin
                        if (!waitRequest) begin
                            busRead  <= 1'b0;
                            busWrite <= 1'b0;
                            if (busWrite) state <= FETCH;  // store done on accept
                        end
                    end else if (readValid) begin
                        state <= WRITEBACK;
                    end
                end
                WRITEBACK: state <= FETCH;
                default:   state <= HALT;
            endcase
        end
    end

    always_comb begin
        ctrl                = '0;
        ctrl.read           = busRead;
        ctrl.write          = busWrite;
        ctrl.useDataAddress = (state == MEMORY) || (state == MEMWAIT);
        ctrl.byteStore      = opcode == OP_SB;
        ctrl.loadInstr      = state == FETCHWAIT;
        ctrl.loadData       = state == MEMWAIT;
        ctrl.loadOperands   = state == DECODE;
        ctrl.useImmediate   = useImm;
        ctrl.readRdAsB      = isStore;  // store data from rd
        ctrl.aluOp          = aluOp;
        ctrl.setFlags       = (state == EXECUTE) && isAlu;
        ctrl.regWrite       = state == WRITEBACK;
        ctrl.wbSource       = isLoad ? WB_LOAD : (isUpper ? WB_UPPER : WB_ALU);
        ctrl.pcIncrement    = state == DECODE;
        ctrl.pcBranch       = (state == EXECUTE) && isBranch && branchTaken;
    end

endmodule

/* hdl/cpu32.sv */
module cpu32 (
    input  logic        clk,
    input  logic        rst,
    input  logic        waitRequest,
    input  logic        readValid,
    input  logic [31:0] dataIn,
    output logic        read,
    output logic        write,
    output logic [3:0]  bwe,
    output logic [31:0] dataOut,
    output logic [31:0] address,
    output logic        halted
);

    import archPkg::*;
    import controlPkg::*;

    controlBus   ctrl;
    instrWord    instructionReg;
    flagBits     flags;
    logic [31:0] dataInReg;
    logic [31:0] registerFileA;
    logic [31:0] registerFileB;
    logic [31:0] aluResult;

    assign read  = ctrl.read;
    assign write = ctrl.write;

    controller
    controller (
        .clk,
        .rst,
        .waitRequest,
        .readValid,
        .instructionReg,
        .flags,
        .ctrl,
        .halted
    );

    addressUnit
    addressUnit (
        .clk,
        .rst,
        .ctrl,
        .instructionReg,
        .aluResult,
        .registerFileB,
        .address,
        .dataOut,
        .bwe
    );

    dataCapture
    dataCapture (
        .clk,
        .rst,
        .readValid,
        .ctrl,
        .dataIn,
        .instructionReg,
        .dataInReg
    );

    registerFile
    registerFile (
        .clk,
        .ctrl,
        .instructionReg,
        .aluResult,
        .dataInReg,
        .registerFileA,
        .registerFileB
    );

    execute
    execute (
        .clk,
        .rst,
        .ctrl,
        .instructionReg,
        .registerFileA,
        .registerFileB,
        .aluResult,
        .flags
    );

endmodule

/* hdl/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// first fetch address
`define RESET_VECTOR 32'h0000_0000

// general purpose registers, r0 reads as zero
`define REG_COUNT 32

// bytes per bus word
`define BYTE_LANES 4

`endif

/* hdl/dataCapture.sv */
module dataCapture (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  readValid,
    input  controlPkg::controlBus ctrl,
    input  logic [31:0]           dataIn,
    output archPkg::instrWord     instructionReg,
    output logic [31:0]           dataInReg
);

    // fetched word
    always_ff @(posedge clk) begin
        if (rst) begin
            instructionReg <= '0;
        end else if (readValid && ctrl.loadInstr) begin
            instructionReg <= dataIn;
        end
    end

    // load word, held for write back
    always_ff @(posedge clk) begin
        if (readValid && ctrl.loadData) begin
            dataInReg <= dataIn;
        end
    end

endmodule

/* hdl/execute.sv */
module execute (
    input  logic                  clk,
    input  logic                  rst,
    input  controlPkg::controlBus ctrl,
    input  archPkg::instrWord     instructionReg,
    input  logic [31:0]           registerFileA,
    input  logic [31:0]           registerFileB,
    output logic [31:0]           aluResult,
    output archPkg::flagBits      flags
);

    import controlPkg::*;

    logic [31:0] aRegister;
    logic [31:0] bRegister;
    logic [32:0] sum;
    logic [4:0]  shiftAmount;
    logic        overflow;

    always_ff @(posedge clk) begin
        if (ctrl.loadOperands) begin
            aRegister <= registerFileA;
            bRegister <= ctrl.useImmediate ?
                {{16{instructionReg.iForm.imm16[15]}}, instructionReg.iForm.imm16} :
                registerFileB;
        end
    end

    assign shiftAmount = bRegister[4:0];

    always_comb begin
        sum       = '0;  // carry and overflow stay clear outside add/sub
        overflow  = 1'b0;
        aluResult = bRegister;
        case (ctrl.aluOp)
            ALU_ADD: begin
                sum       = {1'b0, aRegister} + {1'b0, bRegister};
                aluResult = sum[31:0];
                overflow  = (aRegister[31] == bRegister[31]) && (sum[31] != aRegister[31]);
            end
            ALU_SUB: begin
                sum       = {1'b0, aRegister} + {1'b0, ~bRegister} + 33'd1;  // carry = no borrow
                aluResult = sum[31:0];
                overflow  = (aRegister[31] != bRegister[31]) && (sum[31] != aRegister[31]);
            end
            ALU_AND: aluResult = aRegister & bRegister;
            ALU_OR:  aluResult = aRegister | bRegister;
            ALU_XOR: aluResult = aRegister ^ bRegister;
            ALU_SHL: aluResult = aRegister << shiftAmount;
            ALU_SHR: aluResult = aRegister >> shiftAmount;
            ALU_SAR: aluResult = $unsigned($signed(aRegister) >>> shiftAmount);
            default: aluResult = bRegister;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (ctrl.setFlags) begin
            flags.negative <= aluResult[31];
            flags.zero     <= aluResult == '0;
            flags.carry    <= sum[32];
            flags.overflow <= overflow;
        end
    end

endmodule

/* hdl/registerFile.sv */
`include "cpu_consts.svh"

module registerFile (
    input  logic                  clk,
    input  controlPkg::controlBus ctrl,
    input  archPkg::instrWord     instructionReg,
    input  logic [31:0]           aluResult,
    input  logic [31:0]           dataInReg,
    output logic [31:0]           registerFileA,
    output logic [31:0]           registerFileB
);

    import controlPkg::*;

    logic [31:0] regs [`REG_COUNT];
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  addrB;
    logic [31:0] writeData;

    assign rd    = instructionReg.rForm.rd;
    assign ra    = instructionReg.rForm.ra;
    assign addrB = ctrl.readRdAsB ? rd : instructionReg.rForm.rb;

    assign registerFileA = (ra == '0) ? '0 : regs[ra];
    assign registerFileB = (addrB == '0) ? '0 : regs[addrB];

    always_comb begin
        case (ctrl.wbSource)
            WB_LOAD:  writeData = dataInReg;
            WB_UPPER: writeData = {instructionReg.iForm.imm16, 16'h0000};
            default:  writeData = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.regWrite && rd != '0) begin  // r0 never written
            regs[rd] <= writeData;
        end
    end

endmodule

/* tests/cpuTb.sv */
module cpuTb;

    timeunit 1ns;
    timeprecision 100ps;

    import archPkg::*;

    typedef struct packed {
        logic [31:0] address;
        logic [31:0] data;
        logic [3:0]  bwe;
    } storeRecord;

    localparam int memWords       = 128;
    localparam int programSize    = 40;
    localparam int maxInstrCycles = 19;  // fetch and memory both fully stalled
    localparam int cycleLimit     = programSize * maxInstrCycles * 3;

    logic        clk;
    logic        rst;
    logic        waitRequest;
    logic        readValid;
    logic [31:0] dataIn;
    logic        read;
    logic        write;
    logic [3:0]  bwe;
    logic [31:0] dataOut;
    logic [31:0] address;
    logic        halted;

    logic [31:0] mem [memWords];
    logic [31:0] rngState;
    storeRecord  expectedStores [$];
    int          cycles;

    cpu32 i_cpu32 (
        .clk(clk),
        .rst(rst),
        .waitRequest(waitRequest),
        .readValid(readValid),
        .dataIn(dataIn),
        .read(read),
        .write(write),
        .bwe(bwe),
        .dataOut(dataOut),
        .address(address),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] rInstr(opcodes op, logic [4:0] rd, logic [4:0] ra,
                                           logic [4:0] rb);
        return {op, rd, ra, rb, 11'h000};
    endfunction

    function automatic logic [31:0] iInstr(opcodes op, logic [4:0] rd, logic [4:0] ra,
                                           logic [15:0] imm);
        return {op, rd, ra, imm};
    endfunction

    // skip exactly one instruction when taken
    function automatic logic [31:0] skipIf(conditions cond);
        return iInstr(OP_BR, {1'b0, cond}, 5'd0, 16'd1);
    endfunction

    task automatic abortRun(input string reason);
        $display("sim failed");
        $fatal(1, reason);
    endtask

    task automatic drawDelay(input int unsigned span, output int unsigned value);
        rngState = xorshift(rngState);
        value    = rngState % span;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < memWords; i++) begin
            mem[i] = 32'hd0d0_0000 | 32'(i * 4);
        end
        mem[0]  = iInstr(OP_ADDI, 5'd1, 5'd0, 16'd5);
        mem[1]  = iInstr(OP_ADDI, 5'd2, 5'd0, 16'd3);
        mem[2]  = rInstr(OP_ADD, 5'd3, 5'd1, 5'd2);      // 8
        mem[3]  = rInstr(OP_SUB, 5'd4, 5'd1, 5'd2);      // 2
        mem[4]  = rInstr(OP_OR, 5'd5, 5'd3, 5'd4);       // 0xa
        mem[5]  = rInstr(OP_XOR, 5'd6, 5'd5, 5'd1);      // 0xf
        mem[6]  = rInstr(OP_SHL, 5'd7, 5'd6, 5'd2);      // 0x78
        mem[7]  = iInstr(OP_SW, 5'd7, 5'd0, 16'h0100);
        mem[8]  = iInstr(OP_LUI, 5'd8, 5'd0, 16'h8000);
        mem[9]  = rInstr(OP_SAR, 5'd9, 5'd8, 5'd2);      // 0xf0000000
        mem[10] = rInstr(OP_SHR, 5'd10, 5'd8, 5'd2);     // 0x10000000
        mem[11] = rInstr(OP_SUB, 5'd11, 5'd9, 5'd10);    // 0xe0000000
        mem[12] = iInstr(OP_SW, 5'd11, 5'd0, 16'h0104);
        mem[13] = iInstr(OP_LW, 5'd12, 5'd0, 16'h0100);  // round trip of 0x78
        mem[14] = iInstr(OP_ADDI, 5'd12, 5'd12, 16'd1);  // flags all clear
        mem[15] = iInstr(OP_SW, 5'd12, 5'd0, 16'h0108);
        mem[16] = iInstr(OP_SB, 5'd12, 5'd0, 16'h010d);
        mem[17] = skipIf(EQ);                            // not taken
        mem[18] = iInstr(OP_SW, 5'd1, 5'd0, 16'h0110);
        mem[19] = skipIf(PL);                            // taken
        mem[20] = iInstr(OP_SW, 5'd2, 5'd0, 16'h0114);
        mem[21] = skipIf(CS);                            // not taken
        mem[22] = skipIf(CC);
        mem[23] = iInstr(OP_SW, 5'd2, 5'd0, 16'h0114);
        mem[24] = rInstr(OP_SUB, 5'd13, 5'd1, 5'd1);     // zero and carry
        mem[25] = skipIf(NE);
        mem[26] = skipIf(EQ);
        mem[27] = iInstr(OP_SW, 5'd2, 5'd0, 16'h0114);
        mem[28] = skipIf(CS);
        mem[29] = iInstr(OP_SW, 5'd2, 5'd0, 16'h0114);
        mem[30] = rInstr(OP_ADD, 5'd14, 5'd8, 5'd8);     // carry, overflow, zero
        mem[31] = skipIf(VC);
        mem[32] = skipIf(VS);
        mem[33] = iInstr(OP_SW, 5'd2, 5'd0, 16'h0114);
        mem[34] = iInstr(OP_SW, 5'd3, 5'd0, 16'h0114);
        mem[35] = skipIf(AL);
        mem[36] = iInstr(OP_SW, 5'd2, 5'd0, 16'h0118);
        mem[37] = skipIf(MI);                            // not taken
        mem[38] = iInstr(OP_SB, 5'd1, 5'd0, 16'h0112);
        mem[39] = {OP_HALT, 26'h0};
    endtask

    task automatic loadExpected();
        expectedStores.push_back(storeRecord'{32'h0000_0100, 32'h0000_0078, 4'b1111});
        expectedStores.push_back(storeRecord'{32'h0000_0104, 32'he000_0000, 4'b1111});
        expectedStores.push_back(storeRecord'{32'h0000_0108, 32'h0000_0079, 4'b1111});
        expectedStores.push_back(storeRecord'{32'h0000_010d, 32'h0000_7900, 4'b0010});
        expectedStores.push_back(storeRecord'{32'h0000_0110, 32'h0000_0005, 4'b1111});
        expectedStores.push_back(storeRecord'{32'h0000_0114, 32'h0000_0008, 4'b1111});
        expectedStores.push_back(storeRecord'{32'h0000_0112, 32'h0005_0000, 4'b0100});
    endtask

    task automatic checkStore();
        storeRecord expected;
        if (expectedStores.size() == 0) begin
            abortRun("store seen after the expected list was used up");
        end
        expected = expectedStores.pop_front();
        assert (address == expected.address && dataOut == expected.data
                && bwe == expected.bwe)
        else begin
            $display("error %0t: store %h/%h/%b, expected %h/%h/%b", $time, address,
                     dataOut, bwe, expected.address, expected.data, expected.bwe);
            abortRun("store mismatch");
        end
    endtask

    // one access, from request to acceptance and read data
    task automatic serveAccess();
        int unsigned waits;
        int unsigned latency;
        logic [6:0]  index;
        logic [31:0] word;
        logic        isRead;
        drawDelay(4, waits);
        repeat (waits) begin
            waitRequest = 1'b1;
            @(posedge clk);
            #1;
        end
        waitRequest = 1'b0;
        index       = address[8:2];
        isRead      = read;
        word        = mem[index];
        if (write) begin
            checkStore();
            for (int b = 0; b < 4; b++) begin
                if (bwe[b]) mem[index][b*8 +: 8] = dataOut[b*8 +: 8];
            end
        end
        @(posedge clk);
        #1;
        if (isRead) begin
            drawDelay(3, latency);
            repeat (latency) begin
                @(posedge clk);
                #1;
            end
            readValid = 1'b1;
            dataIn    = word;
            @(posedge clk);
            #1;
            readValid = 1'b0;
        end
    endtask

    initial begin
        @(posedge clk);
        #1;
        forever begin
            if (!rst && (read || write)) begin
                serveAccess();
            end else begin
                @(posedge clk);
                #1;
            end
        end
    end

    initial begin
        rst         = 1'b1;
        waitRequest = 1'b0;
        readValid   = 1'b0;
        dataIn      = '0;
        rngState    = 32'hfa54;
        cycles      = 0;
        loadProgram();
        loadExpected();
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        while (!halted) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles >= cycleLimit) abortRun("timeout, halted never rose");
        end
        repeat (8) @(posedge clk);  // bus must stay quiet after halt
        if (expectedStores.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            abortRun("halted with expected stores still missing");
        end
    end

endmodule

/* tests/cpu_sva.sv */
module cpu_sva (
    input logic        clk,
    input logic        rst,
    input logic        read,
    input logic        write,
    input logic        waitRequest,
    input logic        halted,
    input logic [3:0]  bwe,
    input logic [31:0] address,
    input logic [31:0] dataOut
);

    timeunit 1ns;
    timeprecision 100ps;

    // bus idle out of reset
    resetQuiet: assert property (@(posedge clk) rst |=> !read && !write && bwe == 4'b0000)
        else $error("bus request active during reset");

    oneRequest: assert property (@(posedge clk) disable iff (rst) !(read && write))
        else $error("read and write requested together");

    // request held while the memory stalls
    holdOnWait: assert property (@(posedge clk) disable iff (rst)
        (read || write) && waitRequest |=> $stable(read) && $stable(write)
            && $stable(address) && $stable(dataOut) && $stable(bwe))
        else $error("bus outputs changed under waitRequest");

    byteLane: assert property (@(posedge clk) disable iff (rst)
        write && bwe != 4'b1111 |-> bwe == (4'b0001 << address[1:0]))
        else $error("byte enable not one-hot at address lane");

    quietAfterHalt: assert property (@(posedge clk) disable iff (rst)
        halted |-> !read && !write)
        else $error("bus request after halt");

endmodule

bind cpu32 cpu_sva i_cpuSva (
    .clk(clk),
    .rst(rst),
    .read(read),
    .write(write),
    .waitRequest(waitRequest),
    .halted(halted),
    .bwe(bwe),
    .address(address),
    .dataOut(dataOut)
);
